/* adt_assert.sv */
//######################################
// Concurrent checks bound into the
// address dependency table top level
//######################################

module adt_assert (
   input logic                clk,
   input logic                arst_n_i,
   input logic                flush_i,
   input logic                full_i,
   input logic                empty_i,
   input logic                hit0_i,
   input logic                hit1_i,
   input adt_pkg::entry_vec_t valid_i
);

   timeunit 1ns;
   timeprecision 100ps;

   // Pointer flags agree with the valid bits, so never both at once
   a_not_full_and_empty: assert property (
      @(posedge clk) disable iff (!arst_n_i)
         (!full_i || (valid_i == '1)) && (!empty_i || (valid_i == '0))
   ) else $error("full_o or empty_o disagrees with the entry valid bits");

   // Nothing valid, nothing to hit
   a_no_hit_when_empty: assert property (
      @(posedge clk) disable iff (!arst_n_i) empty_i |-> (!hit0_i && !hit1_i)
   ) else $error("compare hit while the table is empty");

   a_flush_empties: assert property (
      @(posedge clk) disable iff (!arst_n_i) flush_i |=> empty_i
   ) else $error("table not empty after a flush");

endmodule

bind adt_top adt_assert u_assert (
   .clk      (clk),
   .arst_n_i (arst_n_i),
   .flush_i  (flush_i),
   .full_i   (full_o),
   .empty_i  (empty_o),
   .hit0_i   (cmp0_hit_o),
   .hit1_i   (cmp1_hit_o),
   .valid_i  (entry_valid)
);

/* adt_granule.sv */
//######################################
// Alias granularity decoder
// Maps an access size and the address
// alignment to the ignored low bits
//######################################

module adt_granule (
   input  adt_pkg::addr_t addr_i,
   input  adt_pkg::size_t size_i,
   output adt_pkg::gran_t gran_o
);

   adt_pkg::gran_t base_gran;
   logic           aligned;

   always_comb begin
      case (size_i)
         adt_pkg::SIZE_BYTE: begin
            base_gran = 3'd0;
            aligned   = 1'b1;
         end
         adt_pkg::SIZE_HALF: begin
            base_gran = 3'd1;
            aligned   = (addr_i[0] == 1'b0);
         end
         adt_pkg::SIZE_WORD: begin
            base_gran = 3'd2;
            aligned   = (addr_i[1:0] == 2'b00);
         end
         adt_pkg::SIZE_DWORD: begin
            base_gran = 3'd3;
            aligned   = (addr_i[2:0] == 3'b000);
         end
         default: begin
            // Reserved codes end up at granularity 1
            base_gran = 3'd0;
            aligned   = 1'b0;
         end
      endcase
   end

   // Unaligned access may straddle, so widen by one bit
   assign gran_o = aligned ? base_gran : base_gran + 3'd1;

endmodule

/* adt_pkg.sv */
//######################################
// Address dependency table package
// Widths, access size codes and the
// types shared by the table's blocks
//######################################

package adt_pkg;

   // Table geometry
   localparam int ADDR_W = 32;
   localparam int DEPTH  = 4;
   localparam int PTR_W  = 2;

   // Granularity holds the count of ignored low address bits, 0 to 4
   localparam int GRAN_W = 3;
   localparam int SIZE_W = 3;

   // An address as seen by the load/store unit
   typedef logic [ADDR_W-1:0] addr_t;

   // Access size code
   typedef logic [SIZE_W-1:0] size_t;

   // Number of low address bits masked off in a compare
   typedef logic [GRAN_W-1:0] gran_t;

   // Entry index with a wrap bit on top
   typedef logic [PTR_W:0] ptr_t;

   // One bit per table entry
   typedef logic [DEPTH-1:0] entry_vec_t;

   // Per-entry payload as seen by the compare ports
   typedef addr_t addr_arr_t [DEPTH];
   typedef gran_t gran_arr_t [DEPTH];

   // Size codes, everything else is reserved
   localparam size_t SIZE_BYTE  = 3'd1;
   localparam size_t SIZE_HALF  = 3'd2;
   localparam size_t SIZE_WORD  = 3'd3;
   localparam size_t SIZE_DWORD = 3'd4;

endpackage

/* adt_port_match.sv */
//######################################
// Address compare port
// Checks one access for overlap with
// every valid pending store
//######################################

module adt_port_match (
   input  adt_pkg::addr_t      cmp_addr_i,
   input  adt_pkg::size_t      cmp_size_i,
   input  adt_pkg::addr_arr_t  entry_addr_i,
   input  adt_pkg::gran_arr_t  entry_gran_i,
   input  adt_pkg::entry_vec_t entry_valid_i,
   output logic                hit_o
);

   adt_pkg::gran_t      cmp_gran;
   adt_pkg::entry_vec_t match;

   // Granularity of the access being checked
   adt_granule u_cmp_gran (
      .addr_i (cmp_addr_i),
      .size_i (cmp_size_i),
      .gran_o (cmp_gran)
   );

   for (genvar i = 0; i < adt_pkg::DEPTH; i++) begin : g_entry
      adt_pkg::gran_t eff_gran;
      adt_pkg::addr_t keep_mask;
      adt_pkg::addr_t diff;

      // Coarser of the two sides decides the alias window
      assign eff_gran = (entry_gran_i[i] > cmp_gran) ? entry_gran_i[i] : cmp_gran;

      assign keep_mask = {adt_pkg::ADDR_W{1'b1}} << eff_gran;
      assign diff      = cmp_addr_i ^ entry_addr_i[i];

      assign match[i] = entry_valid_i[i] && ((diff & keep_mask) == '0);
   end

   assign hit_o = |match;

endmodule

/* adt_queue.sv */
//######################################
// Pending store address queue
// Four ordered entries of address and
// granularity with head/tail pointers
//######################################

module adt_queue (
   input  logic                clk,
   input  logic                arst_n_i,
   input  logic                flush_i,
   input  logic                push_i,
   input  adt_pkg::addr_t      push_addr_i,
   input  adt_pkg::gran_t      push_gran_i,
   input  logic                pop_i,
   output adt_pkg::addr_arr_t  entry_addr_o,
   output adt_pkg::gran_arr_t  entry_gran_o,
   output adt_pkg::entry_vec_t entry_valid_o,
   output logic                full_o,
   output logic                empty_o
);

   adt_pkg::addr_arr_t        addr_q;
   adt_pkg::gran_arr_t        gran_q;
   adt_pkg::entry_vec_t       valid_q;
   adt_pkg::ptr_t             head_q;
   adt_pkg::ptr_t             tail_q;
   logic [adt_pkg::PTR_W-1:0] head_idx;
   logic [adt_pkg::PTR_W-1:0] tail_idx;
   logic                      push_ok;
   logic                      pop_ok;

   assign head_idx = head_q[adt_pkg::PTR_W-1:0];
   assign tail_idx = tail_q[adt_pkg::PTR_W-1:0];

   // Same index, wrap bits tell full from empty
   assign empty_o = (head_q == tail_q);
   assign full_o  = (head_q[adt_pkg::PTR_W] != tail_q[adt_pkg::PTR_W]) &&
                    (head_idx == tail_idx);

   // Back-pressure and underflow guards
   assign push_ok = push_i && !full_o;
   assign pop_ok  = pop_i && !empty_o;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         head_q  <= '0;
         tail_q  <= '0;
         valid_q <= '0;
      end else if (flush_i) begin
         head_q  <= '0;
         tail_q  <= '0;
         valid_q <= '0;
      end else begin
         // Head and tail only share an index when empty or full,
         // so a push and a pop never touch the same valid bit
         if (push_ok) begin
            valid_q[tail_idx] <= 1'b1;
            tail_q            <= tail_q + 1'b1;
         end
         if (pop_ok) begin
            valid_q[head_idx] <= 1'b0;
            head_q            <= head_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push_ok) begin
         addr_q[tail_idx] <= push_addr_i;
         gran_q[tail_idx] <= push_gran_i;
      end
   end

   assign entry_addr_o  = addr_q;
   assign entry_gran_o  = gran_q;
   assign entry_valid_o = valid_q;

endmodule

/* adt_top.sv */
//######################################
// Address dependency table
// Ordered pending stores with two
// combinational overlap compare ports
//######################################

module adt_top (
   input  logic           clk,
   input  logic           arst_n_i,
   input  logic           flush_i,
   input  logic           push_i,
   input  adt_pkg::addr_t push_addr_i,
   input  adt_pkg::size_t push_size_i,
   input  logic           pop_i,
   input  adt_pkg::addr_t cmp0_addr_i,
   input  adt_pkg::size_t cmp0_size_i,
   output logic           cmp0_hit_o,
   input  adt_pkg::addr_t cmp1_addr_i,
   input  adt_pkg::size_t cmp1_size_i,
   output logic           cmp1_hit_o,
   output logic           full_o,
   output logic           empty_o
);

   adt_pkg::gran_t      push_gran;
   adt_pkg::addr_arr_t  entry_addr;
   adt_pkg::gran_arr_t  entry_gran;
   adt_pkg::entry_vec_t entry_valid;

   // Granularity is fixed once at push time
   adt_granule u_push_gran (
      .addr_i (push_addr_i),
      .size_i (push_size_i),
      .gran_o (push_gran)
   );

   adt_queue u_queue (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .flush_i       (flush_i),
      .push_i        (push_i),
      .push_addr_i   (push_addr_i),
      .push_gran_i   (push_gran),
      .pop_i         (pop_i),
      .entry_addr_o  (entry_addr),
      .entry_gran_o  (entry_gran),
      .entry_valid_o (entry_valid),
      .full_o        (full_o),
      .empty_o       (empty_o)
   );

   adt_port_match u_port0 (
      .cmp_addr_i    (cmp0_addr_i),
      .cmp_size_i    (cmp0_size_i),
      .entry_addr_i  (entry_addr),
      .entry_gran_i  (entry_gran),
      .entry_valid_i (entry_valid),
      .hit_o         (cmp0_hit_o)
   );

   adt_port_match u_port1 (
      .cmp_addr_i    (cmp1_addr_i),
      .cmp_size_i    (cmp1_size_i),
      .entry_addr_i  (entry_addr),
      .entry_gran_i  (entry_gran),
      .entry_valid_i (entry_valid),
      .hit_o         (cmp1_hit_o)
   );

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps --top-module tb_adt \
   -f sources.f -o tb_adt_sim

sim_out=$(./obj_dir/tb_adt_sim 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "All checks passed"; then
   exit 0
else
   exit 1
fi

/* sources.f */
adt_pkg.sv
adt_granule.sv
adt_queue.sv
adt_port_match.sv
adt_top.sv
adt_assert.sv
tb_adt.sv

/* tb_adt.sv */
//######################################
// Testbench for the address dependency
// table, directed and random stimulus
// checked against a queue model
//######################################

module tb_adt;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int RESET_CYCLES = 16;
   localparam int RAND_CYCLES  = 2000;
   // Reset plus directed part plus random part, with a wide margin
   localparam int LIMIT_CYCLES = RESET_CYCLES + RAND_CYCLES + 984;

   logic           clk = 1'b0;
   logic           arst_n;
   logic           flush;
   logic           push;
   adt_pkg::addr_t push_addr;
   adt_pkg::size_t push_size;
   logic           pop;
   adt_pkg::addr_t cmp0_addr;
   adt_pkg::size_t cmp0_size;
   logic           cmp0_hit;
   adt_pkg::addr_t cmp1_addr;
   adt_pkg::size_t cmp1_size;
   logic           cmp1_hit;
   logic           full;
   logic           empty;

   // Model of the pending stores, oldest first
   adt_pkg::addr_t m_addr[$];
   adt_pkg::gran_t m_gran[$];

   logic           want_exp = 1'b0;
   logic           exp0;
   logic           exp1;
   int             cycle_cnt = 0;

   adt_top DUT (
      .clk         (clk),
      .arst_n_i    (arst_n),
      .flush_i     (flush),
      .push_i      (push),
      .push_addr_i (push_addr),
      .push_size_i (push_size),
      .pop_i       (pop),
      .cmp0_addr_i (cmp0_addr),
      .cmp0_size_i (cmp0_size),
      .cmp0_hit_o  (cmp0_hit),
      .cmp1_addr_i (cmp1_addr),
      .cmp1_size_i (cmp1_size),
      .cmp1_hit_o  (cmp1_hit),
      .full_o      (full),
      .empty_o     (empty)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= LIMIT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d clock cycles", LIMIT_CYCLES);
         $display("Checks failed");
         $fatal(1, "timeout");
      end
   end

   // Size picks the base, a misaligned address adds one bit
   function automatic adt_pkg::gran_t model_gran(input adt_pkg::addr_t addr,
                                                 input adt_pkg::size_t size);
      adt_pkg::gran_t g;
      adt_pkg::addr_t low_mask;
      case (size)
         adt_pkg::SIZE_BYTE:  g = 3'd0;
         adt_pkg::SIZE_HALF:  g = 3'd1;
         adt_pkg::SIZE_WORD:  g = 3'd2;
         adt_pkg::SIZE_DWORD: g = 3'd3;
         default:             return 3'd1;
      endcase
      low_mask = (adt_pkg::addr_t'(1) << g) - adt_pkg::addr_t'(1);
      if ((addr & low_mask) != '0)
         g = g + 3'd1;
      return g;
   endfunction

   function automatic logic model_hit(input adt_pkg::addr_t addr, input adt_pkg::size_t size);
      adt_pkg::gran_t g;
      adt_pkg::gran_t e;
      logic           hit;
      g   = model_gran(addr, size);
      hit = 1'b0;
      for (int i = 0; i < m_addr.size(); i++) begin
         e = (m_gran[i] > g) ? m_gran[i] : g;
         if ((addr >> e) == (m_addr[i] >> e))
            hit = 1'b1;
      end
      return hit;
   endfunction

   // Addresses stay in a 64-byte window so overlaps are common
   function automatic adt_pkg::addr_t rand_addr();
      int unsigned r;
      r = $urandom;
      return {{(adt_pkg::ADDR_W-6){1'b0}}, r[5:0]};
   endfunction

   function automatic adt_pkg::size_t rand_size();
      int unsigned r;
      r = $urandom;
      // About one access in eight carries a reserved code
      if (r[2:0] == 3'd0) begin
         if (r[4:3] == 2'd0)
            return 3'd0;
         return 3'd4 + {1'b0, r[4:3]};
      end
      return 3'd1 + {1'b0, r[6:5]};
   endfunction

   task automatic check_hit(input int port, input logic actual, input logic expected);
      if (actual !== expected) begin
         $display("FAIL @%0t: compare port %0d hit is %b, expected %b",
                  $time, port, actual, expected);
         $display("Checks failed");
         $fatal(1, "hit mismatch");
      end
   endtask

   task automatic check_flag(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         $display("FAIL @%0t: %s is %b, expected %b", $time, name, actual, expected);
         $display("Checks failed");
         $fatal(1, "flag mismatch");
      end
   endtask

   // One clock cycle: drive, check before the edge, then follow the edge
   task automatic run_cycle(input logic do_push, input adt_pkg::addr_t addr,
                            input adt_pkg::size_t size, input logic do_pop,
                            input logic do_flush,
                            input adt_pkg::addr_t a0, input adt_pkg::size_t s0,
                            input adt_pkg::addr_t a1, input adt_pkg::size_t s1);
      logic m_full;
      logic m_empty;
      push      = do_push;
      push_addr = addr;
      push_size = size;
      pop       = do_pop;
      flush     = do_flush;
      cmp0_addr = a0;
      cmp0_size = s0;
      cmp1_addr = a1;
      cmp1_size = s1;
      #30;
      m_full  = (m_addr.size() == adt_pkg::DEPTH);
      m_empty = (m_addr.size() == 0);
      check_flag("full_o", full, m_full);
      check_flag("empty_o", empty, m_empty);
      check_hit(0, cmp0_hit, model_hit(a0, s0));
      check_hit(1, cmp1_hit, model_hit(a1, s1));
      if (want_exp) begin
         check_hit(0, cmp0_hit, exp0);
         check_hit(1, cmp1_hit, exp1);
      end
      @(posedge clk);
      if (do_flush) begin
         m_addr.delete();
         m_gran.delete();
      end else begin
         if (do_pop && !m_empty) begin
            void'(m_addr.pop_front());
            void'(m_gran.pop_front());
         end
         if (do_push && !m_full) begin
            m_addr.push_back(addr);
            m_gran.push_back(model_gran(addr, size));
         end
      end
      #2;
   endtask

   task automatic probe(input adt_pkg::addr_t a0, input adt_pkg::size_t s0, input logic e0,
                        input adt_pkg::addr_t a1, input adt_pkg::size_t s1, input logic e1);
      want_exp = 1'b1;
      exp0     = e0;
      exp1     = e1;
      run_cycle(1'b0, '0, adt_pkg::SIZE_BYTE, 1'b0, 1'b0, a0, s0, a1, s1);
      want_exp = 1'b0;
   endtask

   task automatic push_one(input adt_pkg::addr_t addr, input adt_pkg::size_t size);
      run_cycle(1'b1, addr, size, 1'b0, 1'b0, '0, adt_pkg::SIZE_BYTE, '0, adt_pkg::SIZE_BYTE);
   endtask

   task automatic pop_one();
      run_cycle(1'b0, '0, adt_pkg::SIZE_BYTE, 1'b1, 1'b0, '0, adt_pkg::SIZE_BYTE,
                '0, adt_pkg::SIZE_BYTE);
   endtask

   task automatic flush_all();
      run_cycle(1'b0, '0, adt_pkg::SIZE_BYTE, 1'b0, 1'b1, '0, adt_pkg::SIZE_BYTE,
                '0, adt_pkg::SIZE_BYTE);
   endtask

   initial begin : main
      int unsigned r;
      void'($urandom(86082));
      arst_n    = 1'b0;
      flush     = 1'b0;
      push      = 1'b0;
      push_addr = '0;
      push_size = adt_pkg::SIZE_BYTE;
      pop       = 1'b0;
      cmp0_addr = '0;
      cmp0_size = adt_pkg::SIZE_BYTE;
      cmp1_addr = '0;
      cmp1_size = adt_pkg::SIZE_BYTE;
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      arst_n = 1'b1;

      // Reset state
      check_flag("empty_o", empty, 1'b1);
      check_flag("full_o", full, 1'b0);
      probe(rand_addr(), rand_size(), 1'b0, rand_addr(), rand_size(), 1'b0);
      probe(32'h00, adt_pkg::SIZE_DWORD, 1'b0, 32'h3C, 3'd7, 1'b0);

      // Fill, overfill, drain in order, underflow, flush
      push_one(32'h00, adt_pkg::SIZE_WORD);
      push_one(32'h08, adt_pkg::SIZE_WORD);
      push_one(32'h10, adt_pkg::SIZE_WORD);
      push_one(32'h18, adt_pkg::SIZE_WORD);
      push_one(32'h3C, adt_pkg::SIZE_WORD);
      probe(32'h3C, adt_pkg::SIZE_WORD, 1'b0, 32'h18, adt_pkg::SIZE_WORD, 1'b1);
      pop_one();
      probe(32'h00, adt_pkg::SIZE_WORD, 1'b0, 32'h08, adt_pkg::SIZE_WORD, 1'b1);
      pop_one();
      pop_one();
      pop_one();
      probe(32'h18, adt_pkg::SIZE_WORD, 1'b0, 32'h3C, adt_pkg::SIZE_WORD, 1'b0);
      pop_one();
      push_one(32'h24, adt_pkg::SIZE_HALF);
      flush_all();
      probe(32'h24, adt_pkg::SIZE_HALF, 1'b0, 32'h20, adt_pkg::SIZE_DWORD, 1'b0);

      // Exact hit, then gone after the pop
      push_one(32'h20, adt_pkg::SIZE_WORD);
      probe(32'h20, adt_pkg::SIZE_WORD, 1'b1, 32'h24, adt_pkg::SIZE_WORD, 1'b0);
      pop_one();
      probe(32'h20, adt_pkg::SIZE_WORD, 1'b0, 32'h20, adt_pkg::SIZE_WORD, 1'b0);

      // Granularity from size and alignment, coarser side wins
      push_one(32'h10, adt_pkg::SIZE_DWORD);
      probe(32'h17, adt_pkg::SIZE_BYTE, 1'b1, 32'h18, adt_pkg::SIZE_BYTE, 1'b0);
      flush_all();
      push_one(32'h12, adt_pkg::SIZE_WORD);
      probe(32'h16, adt_pkg::SIZE_BYTE, 1'b1, 32'h18, adt_pkg::SIZE_BYTE, 1'b0);
      flush_all();
      push_one(32'h11, adt_pkg::SIZE_BYTE);
      probe(32'h10, adt_pkg::SIZE_DWORD, 1'b1, 32'h12, adt_pkg::SIZE_BYTE, 1'b0);

      // Reserved codes behave as granularity 1 on either port
      flush_all();
      push_one(32'h31, adt_pkg::SIZE_BYTE);
      probe(32'h30, 3'd0, 1'b1, 32'h32, 3'd7, 1'b0);
      probe(32'h33, 3'd6, 1'b0, 32'h30, 3'd5, 1'b1);
      flush_all();

      for (int n = 0; n < RAND_CYCLES; n++) begin
         r = $urandom;
         run_cycle(r[0] | (r[1] & r[2]), rand_addr(), rand_size(), r[3], (r[9:5] == 5'd0),
                   rand_addr(), rand_size(), rand_addr(), rand_size());
      end

      $display("All checks passed");
      $finish;
   end

endmodule
